//--- Makefile
# Verilator build and run of the sprite engine testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= obj_engine_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/obj_pkg.sv
source/obj_ram.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_line_buffer.sv
source/obj_engine.sv
verification/obj_engine_assertions.sv
verification/obj_engine_tb.sv

//--- source/obj_draw.sv
// Sprite draw engine with two-word ROM fetch, pixel reorder and buffer address stepping
module obj_draw #(
    parameter int rom_aw = 14
) (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::obj_req_t  req,
    output logic               draw_busy,
    // Graphics ROM
    output logic [rom_aw-1:0]  rom_addr,
    output logic               rom_cs,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    // Line buffer write side
    output logic [3:0]         pix,
    output logic [3:0]         pal_bank,
    output logic [7:0]         buf_addr,
    output logic               buf_we
);

    import obj_pkg::*;

    logic       accept;
    logic       got_word;
    logic       half;
    logic [2:0] cnt;
    obj_attr_t  cur_attr;
    logic [7:0] cur_code;
    logic [3:0] cur_line;
    rom_word_t  pix_sr;
    logic [7:0] start_addr;

    assign accept   = req.valid && !draw_busy;
    assign got_word = rom_cs && rom_ok;

    // Mirrored sprites start at the right edge and walk left
    assign start_addr = req.xpos + buf_xoffset + (req.attr.hflip ? 8'd15 : 8'd0);

    // 8 code bits, 4 line bits and the half select; upper bits stay zero
    assign rom_addr = rom_aw'({cur_code, cur_line, half});

    assign pix      = pix_sr[3:0];
    assign pal_bank = cur_attr.pal;

    // Control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_busy <= 1'b0;
            rom_cs    <= 1'b0;
            buf_we    <= 1'b0;
            half      <= 1'b0;
            cnt       <= '0;
        end else begin
            if (accept) begin
                draw_busy <= 1'b1;
                rom_cs    <= 1'b1;
                half      <= 1'b0;
            end else if (got_word) begin
                rom_cs <= 1'b0;
                buf_we <= 1'b1;
                cnt    <= '0;
            end else if (buf_we) begin
                cnt <= cnt + 3'd1;
                if (cnt == 3'd7) begin
                    buf_we <= 1'b0;
                    if (half) begin
                        draw_busy <= 1'b0;
                    end else begin
                        // Second word of the row
                        half   <= 1'b1;
                        rom_cs <= 1'b1;
                    end
                end
            end
        end
    end

    // Sprite data and pixel shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_attr <= req.attr;
            cur_code <= req.code;
            cur_line <= req.row ^ {4{req.attr.vflip}};
            buf_addr <= start_addr;
        end
        if (got_word) begin
            pix_sr <= pixel_order(rom_data);
        end else if (buf_we) begin
            pix_sr   <= pix_sr >> 4;
            buf_addr <= cur_attr.hflip ? buf_addr - 8'd1 : buf_addr + 8'd1;
        end
    end

endmodule

//--- source/obj_engine.sv
// Sprite engine top level with sprite RAMs, table scan, draw engine and line buffer
module obj_engine #(
    parameter int rom_aw = 14,
    parameter int buf_aw = 8
) (
    input  logic               clk,
    input  logic               rst,
    // CPU bus
    input  logic [10:0]        cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               obj1_cs,
    input  logic               obj2_cs,
    input  logic               cpu_rnw,
    output logic [7:0]         obj_dout,
    // Video timing
    input  logic               hinit,
    input  logic               LHBL,
    input  logic [7:0]         vrender,
    input  logic [8:0]         hdump,
    input  logic               pxl_cen,
    // Palette loading
    input  logic [7:0]         prog_addr,
    input  logic [3:0]         prog_data,
    input  logic               prog_en,
    // Graphics ROM
    output logic [rom_aw-1:0]  rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    output logic               rom_cs,
    input  logic               rom_ok,
    output logic [3:0]         pxl
);

    import obj_pkg::*;

    logic       obj1_we;
    logic       obj2_we;
    logic [7:0] obj1_q;
    logic [7:0] obj2_q;
    logic       obj1_sel;
    logic [5:0] scan_addr;
    logic [7:0] hi_q;
    logic [7:0] low_q;
    obj_req_t   req;
    logic       draw_busy;
    logic [3:0] pix;
    logic [3:0] pal_bank;
    logic [7:0] buf_addr;
    logic       buf_we;

    assign obj1_we = obj1_cs & ~cpu_rnw;
    assign obj2_we = obj2_cs & ~cpu_rnw;

    // Read data follows the address by one cycle, so the select does too
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj1_sel <= 1'b0;
        end else begin
            obj1_sel <= obj1_cs;
        end
    end

    assign obj_dout = obj1_sel ? obj1_q : obj2_q;

    // xpos and code
    obj_ram u_hi (
        .clk       (clk),
        .cpu_addr  (cpu_addr[5:0]),
        .cpu_din   (cpu_dout),
        .cpu_we    (obj1_we),
        .cpu_q     (obj1_q),
        .scan_addr (scan_addr),
        .scan_q    (hi_q)
    );

    // attr and inverted y
    obj_ram u_low (
        .clk       (clk),
        .cpu_addr  (cpu_addr[5:0]),
        .cpu_din   (cpu_dout),
        .cpu_we    (obj2_we),
        .cpu_q     (obj2_q),
        .scan_addr (scan_addr),
        .scan_q    (low_q)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hinit     (hinit),
        .vrender   (vrender),
        .hi_q      (hi_q),
        .low_q     (low_q),
        .scan_addr (scan_addr),
        .draw_busy (draw_busy),
        .req       (req)
    );

    obj_draw #(.rom_aw(rom_aw)) u_draw (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .draw_busy (draw_busy),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pix       (pix),
        .pal_bank  (pal_bank),
        .buf_addr  (buf_addr),
        .buf_we    (buf_we)
    );

    obj_line_buffer #(.buf_aw(buf_aw)) u_buffer (
        .clk       (clk),
        .rst       (rst),
        .LHBL      (LHBL),
        .pix       (pix),
        .pal_bank  (pal_bank),
        .buf_addr  (buf_addr),
        .buf_we    (buf_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .hdump     (hdump),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl)
    );

endmodule

//--- source/obj_line_buffer.sv
// Palette RAM and ping-pong line buffer with transparent writes and read-and-erase
module obj_line_buffer #(
    parameter int buf_aw = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              LHBL,
    // Draw side
    input  logic [3:0]        pix,
    input  logic [3:0]        pal_bank,
    input  logic [buf_aw-1:0] buf_addr,
    input  logic              buf_we,
    // Palette loading
    input  logic [7:0]        prog_addr,
    input  logic [3:0]        prog_data,
    input  logic              prog_en,
    // Display side
    input  logic [8:0]        hdump,
    input  logic              pxl_cen,
    output logic [3:0]        pxl
);

    localparam int line_depth = 2 ** (buf_aw + 1);

    logic [3:0]        pal_mem  [256];
    logic [3:0]        line_mem [line_depth];

    logic [3:0]        pal_q;
    logic [buf_aw-1:0] wr_addr_d;
    logic              wr_en_d;
    logic              wr_half;
    logic              lhbl_d;
    logic              rd_en;
    logic [buf_aw:0]   rd_addr;

    // Palette, one registered cycle
    always_ff @(posedge clk) begin
        if (prog_en) begin
            pal_mem[prog_addr] <= prog_data;
        end
        pal_q     <= pal_mem[{pal_bank, pix}];
        wr_addr_d <= buf_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en_d <= 1'b0;
            wr_half <= 1'b0;
            lhbl_d  <= 1'b0;
        end else begin
            wr_en_d <= buf_we;
            lhbl_d  <= LHBL;
            // Swap at the start of blanking
            if (lhbl_d && !LHBL) begin
                wr_half <= ~wr_half;
            end
        end
    end

    // Display reads the half not being drawn
    assign rd_en   = LHBL && pxl_cen;
    assign rd_addr = {~wr_half, hdump[buf_aw-1:0]};

    always_ff @(posedge clk) begin
        // Colour 0 is transparent
        if (wr_en_d && pal_q != 4'd0) begin
            line_mem[{wr_half, wr_addr_d}] <= pal_q;
        end
        if (rd_en) begin
            line_mem[rd_addr] <= 4'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= 4'd0;
        end else if (rd_en) begin
            pxl <= line_mem[rd_addr];
        end
    end

endmodule

//--- source/obj_pkg.sv
// Sprite table constants, attribute and draw request structs, ROM word type, pixel reorder
package obj_pkg;

    // Sprite table geometry
    localparam int obj_entries = 24;
    localparam int obj_height  = 16;

    // Offset from sprite xpos to the first line buffer column
    localparam logic [7:0] buf_xoffset = 8'd6;

    // Attribute byte as stored in the low sprite RAM
    typedef struct packed {
        logic       vflip;
        logic       hflip;
        logic [1:0] unused;
        logic [3:0] pal;
    } obj_attr_t;

    // Request handed from the table scan to the draw engine
    typedef struct packed {
        obj_attr_t  attr;
        logic [7:0] code;
        logic [7:0] xpos;
        logic [3:0] row;
        logic       valid;
    } obj_req_t;

    // One ROM word holding eight 4-bit pixels, bits interleaved
    typedef logic [31:0] rom_word_t;

    // Reorder a ROM word so that pixel n sits at bits [4n+3:4n].
    // Pixel n for n < 4 takes bits {n+8, n+12, n, n+4}, high to low;
    // pixels 4..7 use the same pattern moved up by 16 bits
    function automatic rom_word_t pixel_order(rom_word_t w);
        rom_word_t p;
        int        base;
        for (int n = 0; n < 8; n++) begin
            base = (n < 4) ? n : n + 12;
            p[4*n +: 4] = {w[base+8], w[base+12], w[base], w[base+4]};
        end
        return p;
    endfunction

endpackage

//--- source/obj_ram.sv
// Byte-wide dual-port sprite RAM with CPU read/write port and scan read port
module obj_ram (
    input  logic       clk,
    // CPU side
    input  logic [5:0] cpu_addr,
    input  logic [7:0] cpu_din,
    input  logic       cpu_we,
    output logic [7:0] cpu_q,
    // Table scan side
    input  logic [5:0] scan_addr,
    output logic [7:0] scan_q
);

    logic [7:0] mem [64];

    // CPU port, read-first
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Scan port is read only
    always_ff @(posedge clk) begin
        scan_q <= mem[scan_addr];
    end

endmodule

//--- source/obj_scan.sv
// Sprite table scanner with vertical band test and draw request generation
module obj_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              hinit,
    input  logic [7:0]        vrender,
    input  logic [7:0]        hi_q,
    input  logic [7:0]        low_q,
    output logic [5:0]        scan_addr,
    input  logic              draw_busy,
    output obj_pkg::obj_req_t req
);

    import obj_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_read_a,
        s_read_b,
        s_wait
    } scan_state_t;

    scan_state_t state;
    logic [4:0]  entry;
    logic [7:0]  ypos;
    logic [8:0]  band_end;
    logic [7:0]  ydiff;
    logic        in_band;
    logic        last;

    logic        req_valid;
    obj_attr_t   req_attr;
    logic [7:0]  req_code;
    logic [7:0]  req_xpos;
    logic [3:0]  req_row;

    // Y is stored inverted in the odd entries of the low RAM
    assign ypos     = ~low_q;
    assign band_end = {1'b0, vrender} + 9'(obj_height);
    assign in_band  = (ypos >= vrender) && ({1'b0, ypos} < band_end);
    assign ydiff    = vrender - ypos - 8'd1;
    assign last     = entry == 5'(obj_entries - 1);

    // RAM reads are registered, so point at the odd entry one cycle ahead.
    // While stalled, keep the even entry on the bus
    assign scan_addr = {entry, (state == s_read_a) && !draw_busy};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= s_idle;
            entry     <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (hinit) begin
                        state <= s_read_a;
                    end
                end
                s_read_a: begin
                    if (!draw_busy) begin
                        state <= s_read_b;
                    end
                end
                s_read_b: begin
                    req_valid <= in_band;
                    if (last) begin
                        entry <= '0;
                        state <= s_idle;
                    end else begin
                        entry <= entry + 5'd1;
                        state <= s_wait;
                    end
                end
                // Lets draw_busy rise before the next read
                s_wait: state <= s_read_a;
                default: state <= s_idle;
            endcase
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (state == s_read_a && !draw_busy) begin
            req_xpos <= hi_q;
            req_attr <= low_q;
        end
        if (state == s_read_b) begin
            req_code <= hi_q;
            req_row  <= ydiff[3:0];
        end
    end

    assign req = '{attr: req_attr, code: req_code, xpos: req_xpos,
                   row: req_row, valid: req_valid};

endmodule

//--- verification/obj_engine_assertions.sv
// Concurrent assertions on the draw engine ROM port and request handshake
module obj_engine_assertions (
    input logic              clk,
    input logic              rst,
    input logic              rom_cs,
    input logic              rom_ok,
    input logic              buf_we,
    input logic              draw_busy,
    input obj_pkg::obj_req_t req
);

    timeunit 1ns;
    timeprecision 100ps;

    // ROM request level stays up until the data arrives
    rom_cs_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs)
        else $error("rom_cs dropped before rom_ok");

    // Scanner never offers a request to a busy engine
    req_when_free: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> !draw_busy)
        else $error("draw request while draw engine busy");

    no_write_during_fetch: assert property (@(posedge clk) disable iff (rst)
        !(buf_we && rom_cs))
        else $error("buffer write while ROM fetch pending");

endmodule

//--- verification/obj_engine_tb.sv
// Sprite engine testbench with ROM model, table and palette loading, reference line renderer
module obj_engine_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import obj_pkg::*;

    localparam int n_lines        = 13;
    localparam int max_delay      = 7;
    localparam int draw_wait      = obj_entries * (4 + 2 * (max_delay + 9)) + 20;
    localparam int timeout_cycles = n_lines * (draw_wait + 280) + 4000;

    logic        clk;
    logic        rst;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        obj1_cs;
    logic        obj2_cs;
    logic        cpu_rnw;
    logic [7:0]  obj_dout;
    logic        hinit;
    logic        LHBL;
    logic [7:0]  vrender;
    logic [8:0]  hdump;
    logic        pxl_cen;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic        prog_en;
    logic [13:0] rom_addr;
    logic [31:0] rom_data = '0;
    logic        rom_cs;
    logic        rom_ok = 1'b0;
    logic [3:0]  pxl;

    logic [7:0]  tab_hi [64];
    logic [7:0]  tab_lo [64];
    logic [3:0]  pal [256];
    logic [3:0]  pend_line [256];
    logic [3:0]  cmp_line [256];
    logic [7:0]  line_v [n_lines];
    logic [15:0] lfsr_state = 16'd54109;
    logic        compare_on = 1'b0;
    logic        chk_valid = 1'b0;
    logic [7:0]  chk_addr;
    int          shown_line = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        rom_busy = 1'b0;
    int          rom_delay = 0;

    obj_engine #(.rom_aw(14), .buf_aw(8)) i_obj_engine (.*);

    bind obj_draw obj_engine_assertions a_draw (
        .clk(clk), .rst(rst), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .buf_we(buf_we), .draw_busy(draw_busy), .req(req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Pixel n stored at ROM address a, taken from a fixed scramble of the address
    function automatic logic [3:0] rom_pixel(input logic [13:0] a, input int n);
        logic [31:0] h;
        h = (32'(a) * 32'h9E3779B1) ^ {a[3:0], 28'h0};
        return h[4*n +: 4];
    endfunction

    // ROM word in the interleaved order. Each 16-bit group holds four pixels
    // as planes 1, 0, 3 and 2 from the low nibble up
    function automatic logic [31:0] rom_word(input logic [13:0] a);
        logic [31:0] w;
        logic [3:0]  p;
        for (int n = 0; n < 8; n++) begin
            p = rom_pixel(a, n);
            w[16*(n/4) + n%4]      = p[1];
            w[16*(n/4) + 4 + n%4]  = p[0];
            w[16*(n/4) + 8 + n%4]  = p[3];
            w[16*(n/4) + 12 + n%4] = p[2];
        end
        return w;
    endfunction

    // ROM model with rom_ok 1 to 7 cycles after rom_cs rises
    always @(posedge clk) begin
        int d;
        rom_ok <= 1'b0;
        if (rst) begin
            rom_busy <= 1'b0;
        end else if (!rom_ok) begin
            if (rom_cs && !rom_busy) begin
                take_bits(3, d);
                d = (d % 7) + 1;
                if (d == 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                end else begin
                    rom_delay <= d - 1;
                    rom_busy  <= 1'b1;
                end
            end else if (rom_busy) begin
                if (rom_delay == 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    rom_busy <= 1'b0;
                end else begin
                    rom_delay <= rom_delay - 1;
                end
            end
        end
    end

    // Expected line for render line v with sprites drawn in table order
    function automatic void render_line(input logic [7:0] v);
        logic [7:0]  x;
        logic [7:0]  code;
        logic [7:0]  attr;
        logic [7:0]  y;
        logic [3:0]  row;
        logic [3:0]  ln;
        logic [3:0]  p;
        logic [3:0]  c;
        logic [7:0]  a;
        int          k;
        for (int i = 0; i < 256; i++) begin
            pend_line[i] = 4'd0;
        end
        for (int e = 0; e < obj_entries; e++) begin
            x    = tab_hi[2*e];
            code = tab_hi[2*e+1];
            attr = tab_lo[2*e];
            y    = ~tab_lo[2*e+1];
            if (y >= v && {1'b0, y} < {1'b0, v} + 9'd16) begin
                row = 4'(v - y - 8'd1);
                ln  = attr[7] ? ~row : row;
                for (int h = 0; h < 2; h++) begin
                    for (int n = 0; n < 8; n++) begin
                        p = rom_pixel({1'b0, code, ln, h[0]}, n);
                        k = h * 8 + n;
                        a = x + buf_xoffset + (attr[6] ? 8'(15 - k) : 8'(k));
                        c = pal[{attr[3:0], p}];
                        if (c != 4'd0) begin
                            pend_line[a] = c;
                        end
                    end
                end
            end
        end
    endfunction

    task automatic set_entry(input int e, input logic [7:0] x, input logic [7:0] code,
                             input logic [7:0] attr, input logic [7:0] y);
        tab_hi[2*e]   = x;
        tab_hi[2*e+1] = code;
        tab_lo[2*e]   = attr;
        tab_lo[2*e+1] = ~y;
    endtask

    task automatic cpu_write(input logic hi, input int a, input logic [7:0] d);
        @(posedge clk);
        cpu_addr <= 11'(a);
        cpu_dout <= d;
        obj1_cs  <= hi;
        obj2_cs  <= !hi;
        cpu_rnw  <= 1'b0;
        @(posedge clk);
        obj1_cs <= 1'b0;
        obj2_cs <= 1'b0;
        cpu_rnw <= 1'b1;
    endtask

    task automatic cpu_check(input logic hi, input int a, input logic [7:0] exp);
        @(posedge clk);
        cpu_addr <= 11'(a);
        obj1_cs  <= hi;
        obj2_cs  <= !hi;
        cpu_rnw  <= 1'b1;
        @(posedge clk);
        obj1_cs <= 1'b0;
        obj2_cs <= 1'b0;
        @(negedge clk);
        checks++;
        if (obj_dout !== exp) begin
            errors++;
            $display("** Error at %0t: RAM %s address %0d read %h, expected %h",
                     $time, hi ? "hi" : "low", a, obj_dout, exp);
        end
    endtask

    // Draw one line, then show the previously drawn one
    task automatic run_line(input int k);
        cmp_line   = pend_line;
        shown_line = k - 1;
        render_line(line_v[k]);
        compare_on = (k >= 2);
        @(posedge clk);
        vrender <= line_v[k];
        hinit   <= 1'b1;
        @(posedge clk);
        hinit <= 1'b0;
        repeat (draw_wait) @(posedge clk);
        for (int h = 0; h < 256; h++) begin
            @(posedge clk);
            LHBL    <= 1'b1;
            pxl_cen <= 1'b1;
            hdump   <= 9'(h);
        end
        @(posedge clk);
        LHBL    <= 1'b0;
        pxl_cen <= 1'b0;
        hdump   <= '0;
        repeat (4) @(posedge clk);
    endtask

    // Display side comparison where pxl follows the read address by one cycle
    always @(posedge clk) begin
        chk_valid <= LHBL && pxl_cen && compare_on;
        chk_addr  <= hdump[7:0];
    end

    always @(negedge clk) begin
        if (chk_valid) begin
            checks++;
            if (pxl !== cmp_line[chk_addr]) begin
                errors++;
                $display("** Error at %0t: line %0d pixel %0d is %h, expected %h",
                         $time, shown_line, chk_addr, pxl, cmp_line[chk_addr]);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int r;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_dout  = '0;
        obj1_cs   = 1'b0;
        obj2_cs   = 1'b0;
        cpu_rnw   = 1'b1;
        hinit     = 1'b0;
        LHBL      = 1'b0;
        vrender   = '0;
        hdump     = '0;
        pxl_cen   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        line_v = '{8'd100, 8'd100, 8'd100, 8'd97, 8'd104, 8'd200, 8'd110,
                   8'd85, 8'd115, 8'd200, 8'd100, 8'd124, 8'd200};
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Band edges, flips and overlap around line 100
        set_entry(0, 8'd20, 8'd3, 8'h01, 8'd100);
        set_entry(1, 8'd40, 8'd17, 8'h42, 8'd115);
        set_entry(2, 8'd60, 8'd29, 8'h01, 8'd116);
        set_entry(3, 8'd80, 8'd41, 8'h02, 8'd99);
        set_entry(4, 8'd100, 8'd55, 8'h83, 8'd108);
        set_entry(5, 8'd104, 8'd66, 8'hC4, 8'd108);
        set_entry(6, 8'd250, 8'd77, 8'h05, 8'd105);
        // Remaining sprites stay clear of lines 184 and up
        for (int e = 7; e < obj_entries; e++) begin
            take_bits(8, r);
            tab_hi[2*e] = 8'(r);
            take_bits(8, r);
            tab_hi[2*e+1] = 8'(r);
            take_bits(8, r);
            tab_lo[2*e] = 8'(r);
            take_bits(8, r);
            tab_lo[2*e+1] = ~8'(60 + r % 80);
        end
        for (int e = 2 * obj_entries; e < 64; e++) begin
            tab_hi[e] = 8'(e * 3);
            tab_lo[e] = 8'(e * 5 + 1);
        end
        for (int i = 0; i < 256; i++) begin
            take_bits(4, r);
            pal[i] = 4'(r);
        end
        // Half of bank 4 transparent so sprite 4 shows through sprite 5
        for (int i = 0; i < 8; i++) begin
            pal[64 + i] = 4'd0;
        end

        for (int a = 0; a < 64; a++) begin
            cpu_write(1'b1, a, tab_hi[a]);
            cpu_write(1'b0, a, tab_lo[a]);
        end
        for (int a = 0; a < 64; a++) begin
            cpu_check(1'b1, a, tab_hi[a]);
            cpu_check(1'b0, a, tab_lo[a]);
        end

        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            prog_addr <= 8'(i);
            prog_data <= pal[i];
            prog_en   <= 1'b1;
        end
        @(posedge clk);
        prog_en <= 1'b0;

        for (int k = 0; k < n_lines; k++) begin
            run_line(k);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
